// File: bridge_cases.txt
# columns (hex): dqtype awaddr awlen awsize awburst dadr reads full_strb
# awsize is the AXI size code, awburst 1 = INCR 2 = WRAP, full_strb 0 = random strobes
1 00 3 4 1 0 6 1
1 40 1 4 1 3 4 0
1 13 7 0 1 1 2 0
1 26 9 2 1 2 3 0
1 38 3 2 2 3 2 1
1 a0 3 4 2 8 4 0
0 70 1 4 1 7 5 1
0 e8 7 3 2 c 8 0
0 05 5 1 1 f 4 0
1 80 f 3 1 8 8 1
1 5a f 1 2 4 2 0
0 f4 0 2 1 f 2 1

// File: sources.f
+incdir+.
axi_pkg.sv
mba_pkg.sv
bridge_ifs.sv
aw_cmd_queue.sv
wbeat_steer.sv
wdata_buffer.sv
arb_drain.sv
axi_wdata_bridge.sv
bridge_checker.sv
tb_axi_wdata_bridge.sv

// File: tb_axi_wdata_bridge.sv
// needs bridge_cases.txt in the run directory; every case needs a read count of 2 or more
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_axi_wdata_bridge;

   logic                   CLK;
   logic                   ZRESET;
   logic                   dqtype;
   logic [`BRG_ADDR_W-1:0] awaddr;
   logic [7:0]             awlen;
   logic [2:0]             awsize;
   logic [1:0]             awburst;
   logic                   avalid;
   logic [`BRG_DATA_W-1:0] wdata;
   logic [`BRG_STRB_W-1:0] wstrb;
   logic                   wlast;
   logic                   wvalid;
   logic                   wready;
   logic                   arb_wak_n;
   logic [`BRG_DATA_W-1:0] arb_rdt;
   logic [`BRG_STRB_W-1:0] arb_ben_n;
   logic                   dreq;
   logic [`BRG_BUF_AW-1:0] dadr;
   logic                   dready;
   logic                   dend;

   // case table with one row per line of the file
   int c_dq    [32];
   int c_addr  [32];
   int c_len   [32];
   int c_size  [32];
   int c_burst [32];
   int c_dadr  [32];
   int c_reads [32];
   int c_full  [32];
   int ncases;
   int errors;
   int checks;
   int cycles;
   int cycle_limit;
   bit await_drain;   // last beat taken and dend not seen yet

   // reference image of the staging buffer
   logic [`BRG_DATA_W-1:0] img_word  [16];
   logic [`BRG_STRB_W-1:0] img_be    [16];
   bit   [15:0]            img_wr;
   logic [`BRG_DATA_W-1:0] beat_data [16];
   logic [`BRG_STRB_W-1:0] beat_strb [16];

   axi_wdata_bridge uut (.*);

   initial CLK = 1'b0;
   always #20 CLK = ~CLK;

   task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // ====================
   // reference model
   // ====================
   task automatic make_beats(input int c);
      int r;
      for (int b = 0; b <= c_len[c]; b++) begin
         beat_data[b] = {$urandom, $urandom, $urandom, $urandom};
         r = $urandom;
         beat_strb[b] = c_full[c] ? 16'hFFFF : r[15:0];
      end
   endtask

   task automatic build_image(input int c);
      int nbytes;
      int span;
      int addr;
      int base;
      int lane;
      img_wr = '0;
      for (int i = 0; i < 16; i++) begin
         img_word[i] = '0;
         img_be[i]   = '0;
      end
      nbytes = 1 << ((c_size[c] > 4) ? 4 : c_size[c]);
      addr   = c_addr[c] & ~(nbytes - 1);      // start aligned to beat size
      span   = (c_len[c] + 1) * nbytes;
      for (int b = 0; b <= c_len[c]; b++) begin
         for (int k = 0; k < nbytes; k++) begin
            lane = addr % 16 + k;
            if (beat_strb[b][lane]) begin
               img_word[addr / 16][lane * 8 +: 8] = beat_data[b][lane * 8 +: 8];
               img_be[addr / 16][lane] = 1'b1;
            end
         end
         img_wr[addr / 16] = 1'b1;
         if (c_burst[c] == 2) begin
            base = addr - addr % span;   // wrap block start
            addr = base + (addr - base + nbytes) % span;
         end else begin
            addr = (addr + nbytes) % 256;
         end
      end
   endtask

   // word j of the drain with two words per entry in x16
   task automatic predict(input int c, input int j, output logic [127:0] d,
                          output logic [15:0] bn);
      int           e;
      bit           hi;
      logic [127:0] w;
      logic [15:0]  wb;
      e  = c_dq[c] ? (c_dadr[c] + j) % 16 : (c_dadr[c] + j / 2) % 16;
      hi = (c_dq[c] == 0) && (j % 2 == 1);
      w  = img_wr[e] ? img_word[e] : '0;
      wb = img_wr[e] ? ~img_be[e] : '1;
      d  = w;
      bn = wb;
      if (c_dq[c] == 0) begin
         d        = '0;
         bn       = '1;
         d[31:0]  = hi ? w[95:64] : w[31:0];
         d[95:64] = hi ? w[127:96] : w[63:32];
         bn[3:0]  = hi ? wb[11:8] : wb[3:0];
         bn[11:8] = hi ? wb[15:12] : wb[7:4];
      end
   endtask

   // ====================
   // stimulus
   // ====================
   task automatic push_cmd(input int c);
      @(posedge CLK);
      avalid  <= 1'b1;
      awaddr  <= 8'(c_addr[c]);
      awlen   <= 8'(c_len[c]);
      awsize  <= 3'(c_size[c]);
      awburst <= 2'(c_burst[c]);
   endtask

   task automatic drive_beat(input int c, input int b);
      wvalid <= 1'b1;
      wdata  <= beat_data[b];
      wstrb  <= beat_strb[b];
      wlast  <= (b == c_len[c]);
   endtask

   task automatic send_beats(input int c);
      int b;
      b = 0;
      @(posedge CLK);
      drive_beat(c, 0);
      while (b <= c_len[c]) begin
         @(negedge CLK);
         if (wready) begin        // taken on the coming edge
            @(posedge CLK);
            b++;
            if (b <= c_len[c]) begin
               drive_beat(c, b);
            end else begin
               wvalid <= 1'b0;
               wlast  <= 1'b0;
            end
         end
      end
      await_drain = 1'b1;
   endtask

   task automatic drain_case(input int c);
      logic [127:0] exp_d;
      logic [15:0]  exp_b;
      do @(negedge CLK); while (!dready);
      @(posedge CLK);
      dreq   <= 1'b1;
      dadr   <= 4'(c_dadr[c]);
      dqtype <= c_dq[c][0];
      fork
         begin
            @(posedge CLK);
            dreq <= 1'b0;
            @(posedge CLK);
            for (int i = 0; i < c_reads[c] - 1; i++) begin
               arb_wak_n <= 1'b0;   // one more read per low cycle
               @(posedge CLK);
            end
            arb_wak_n <= 1'b1;
         end
         begin
            repeat (2) @(posedge CLK);
            for (int j = 0; j < c_reads[c]; j++) begin
               @(posedge CLK);
               @(negedge CLK);
               predict(c, j, exp_d, exp_b);
               check_value(arb_rdt, exp_d, "arb_rdt");
               check_value(arb_ben_n, exp_b, "arb_ben_n");
               check_value(dend, j == c_reads[c] - 1, "dend");
            end
            check_value(dready, 1'b0, "dready after drain");
            await_drain = 1'b0;
         end
      join
   endtask

   always @(negedge CLK) begin
      if (await_drain) check_value(wready, 1'b0, "wready while burst awaits drain");
   end

   // ====================
   // run control
   // ====================
   always @(posedge CLK) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         errors = errors + 1 + uut.u_chk.fails;
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      int    fd;
      int    n;
      string line;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      ncases      = 0;
      cycle_limit = 350;
      await_drain = 1'b0;
      ZRESET      = 1'b0;
      dqtype      = 1'b1;
      awaddr      = '0;
      awlen       = '0;
      awsize      = '0;
      awburst     = '0;
      avalid      = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wlast       = 1'b0;
      wvalid      = 1'b0;
      arb_wak_n   = 1'b1;
      dreq        = 1'b0;
      dadr        = '0;
      n = $urandom(24);
      fd = $fopen("bridge_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open bridge_cases.txt, no cases were run");
         errors++;
      end else begin
         while (!$feof(fd) && ncases < 32) begin
            n = $fgets(line, fd);
            if (n > 0) begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h", c_dq[ncases], c_addr[ncases],
                           c_len[ncases], c_size[ncases], c_burst[ncases], c_dadr[ncases],
                           c_reads[ncases], c_full[ncases]);
               if (n == 8) ncases++;   // header lines do not parse
            end
         end
         $fclose(fd);
      end
      cycle_limit = 300 * ncases + 50;

      @(posedge CLK);
      @(negedge CLK);
      check_value(wready, 1'b0, "wready in reset");
      check_value(arb_ben_n, 16'hFFFF, "arb_ben_n in reset");
      @(posedge CLK);
      ZRESET <= 1'b1;
      @(negedge CLK);
      check_value(wready, 1'b0, "wready after reset");
      check_value(dready, 1'b0, "dready after reset");
      check_value(dend, 1'b0, "dend after reset");
      check_value(arb_ben_n, 16'hFFFF, "arb_ben_n after reset");

      // commands go in pairs and the second waits in the queue
      for (int c = 0; c < ncases; c++) begin
         if (c % 2 == 0) begin
            push_cmd(c);
            if (c + 1 < ncases) push_cmd(c + 1);
            @(posedge CLK);
            avalid <= 1'b0;
         end
         make_beats(c);
         build_image(c);
         send_beats(c);
         drain_case(c);
      end

      repeat (4) @(posedge CLK);
      errors = errors + uut.u_chk.fails;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: bridge_checker.sv
// bound into the bridge top; reaches the queue fill count and the drain read-valid inside it
`timescale 1ns/1ps
`include "bridge_config.svh"

module bridge_checker (
   input logic        CLK,
   input logic        ZRESET,
   input logic        avalid,
   input logic        q_full,
   input logic        wready,
   input logic        burst_done,
   input logic        drain_done,
   input logic        dend,
   input logic        dqtype,
   input logic        out_upd,      // drain output register loads
   input logic [15:0] arb_ben_n
);

   int   fails = 0;
   logic awaiting;   // burst in buffer, drain not finished

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) awaiting <= 1'b0;
      else if (burst_done) awaiting <= 1'b1;
      else if (drain_done) awaiting <= 1'b0;
   end

   // ====================
   // properties
   // ====================
   a_dend_pulse: assert property (@(posedge CLK) disable iff (!ZRESET) dend |=> !dend)
   else begin
      $error("dend held longer than one cycle");
      fails++;
   end

   a_wready_hold: assert property (@(posedge CLK) disable iff (!ZRESET) awaiting |-> !wready)
   else begin
      $error("wready high while a burst awaits drain");
      fails++;
   end

   a_queue_full: assert property (@(posedge CLK) disable iff (!ZRESET) avalid |-> !q_full)
   else begin
      $error("avalid pushed into a full command queue");
      fails++;
   end

   // x16 leaves odd lanes disabled
   a_x16_lanes: assert property (@(posedge CLK) disable iff (!ZRESET)
      (out_upd && !dqtype) |=> (arb_ben_n[7:4] == 4'hF && arb_ben_n[15:12] == 4'hF))
   else begin
      $error("x16 output enables lanes 1 or 3");
      fails++;
   end

endmodule

bind axi_wdata_bridge bridge_checker u_chk (
   .CLK(CLK), .ZRESET(ZRESET), .avalid(avalid), .q_full(u_queue.count[`BRG_CMDQ_AW]),
   .wready(wready), .burst_done(burst_done), .drain_done(drain_done), .dend(dend),
   .dqtype(dqtype), .out_upd(u_drain.rv), .arb_ben_n(arb_ben_n)
);

// File: axi_wdata_bridge.sv
// AXI write data to MBA bridge; no slave error, sender must not overfill the command queue
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_wdata_bridge (
   input  logic                   CLK,
   input  logic                   ZRESET,
   input  logic                   dqtype,
   input  logic [`BRG_ADDR_W-1:0] awaddr,
   input  logic [7:0]             awlen,
   input  logic [2:0]             awsize,
   input  logic [1:0]             awburst,
   input  logic                   avalid,
   input  logic [`BRG_DATA_W-1:0] wdata,
   input  logic [`BRG_STRB_W-1:0] wstrb,
   input  logic                   wlast,
   input  logic                   wvalid,
   output logic                   wready,
   input  logic                   arb_wak_n,
   output logic [`BRG_DATA_W-1:0] arb_rdt,
   output logic [`BRG_STRB_W-1:0] arb_ben_n,
   input  logic                   dreq,
   input  logic [`BRG_BUF_AW-1:0] dadr,
   output logic                   dready,
   output logic                   dend
);

   // ====================
   // internal links
   // ====================
   burst_cmd_if cmd ();
   wbuf_if      wbus ();
   logic        burst_done;   // last beat written
   logic        drain_done;   // same as dend

   aw_cmd_queue u_queue (
      .CLK(CLK), .ZRESET(ZRESET), .push(avalid), .push_addr(awaddr),
      .push_len(awlen), .push_size(awsize), .push_burst(awburst), .cmd(cmd.queue)
   );

   wbeat_steer u_steer (
      .CLK(CLK), .ZRESET(ZRESET), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
      .wvalid(wvalid), .drain_done(drain_done), .wready(wready),
      .burst_done(burst_done), .cmd(cmd.steer), .wbuf(wbus.writer)
   );

   wdata_buffer u_buffer (.CLK(CLK), .ZRESET(ZRESET), .wbuf(wbus.buffer));

   arb_drain u_drain (
      .CLK(CLK), .ZRESET(ZRESET), .dqtype(dqtype), .arb_wak_n(arb_wak_n), .dreq(dreq),
      .dadr(dadr), .burst_done(burst_done), .arb_rdt(arb_rdt), .arb_ben_n(arb_ben_n),
      .dready(dready), .dend(dend), .drain_done(drain_done), .wbuf(wbus.reader)
   );

endmodule

// File: arb_drain.sv
// drain toward the arbiter; arb_wak_n must go low at least once or no dend is given
`timescale 1ns/1ps
`include "bridge_config.svh"

module arb_drain (
   input  logic                   CLK,
   input  logic                   ZRESET,
   input  logic                   dqtype,      // 1 = x32, 0 = x16
   input  logic                   arb_wak_n,
   input  logic                   dreq,
   input  logic [`BRG_BUF_AW-1:0] dadr,
   input  logic                   burst_done,
   output logic [`BRG_DATA_W-1:0] arb_rdt,
   output logic [`BRG_STRB_W-1:0] arb_ben_n,
   output logic                   dready,
   output logic                   dend,
   output logic                   drain_done,
   wbuf_if.reader                 wbuf
);

   localparam int LB = mba_pkg::LANE_W / 8;   // enables per lane

   logic                   dreq_q;
   logic                   drain_act;
   logic                   low_seen;   // wak_n went low in this drain
   logic                   wak_rise;
   logic                   re;
   logic                   rv;         // read data valid at buffer
   logic [`BRG_BUF_AW-1:0] rptr;
   logic                   half;       // x16 half of next read
   logic                   half_q;     // half of data at buffer

   mba_pkg::mba_word_u     rdt_nx;
   logic [`BRG_STRB_W-1:0] ben_nx;

   assign re       = dreq_q | (drain_act & ~arb_wak_n);
   assign wak_rise = low_seen & arb_wak_n;

   // ====================
   // drain control
   // ====================
   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         dready    <= 1'b0;
         dreq_q    <= 1'b0;
         drain_act <= 1'b0;
         low_seen  <= 1'b0;
         dend      <= 1'b0;
         rv        <= 1'b0;
      end else begin
         if (burst_done) dready <= 1'b1;
         else if (dreq)  dready <= 1'b0;
         dreq_q <= dreq;
         if (dreq)          drain_act <= 1'b1;
         else if (wak_rise) drain_act <= 1'b0;
         if (wak_rise)                    low_seen <= 1'b0;
         else if (drain_act & ~arb_wak_n) low_seen <= 1'b1;
         dend <= wak_rise;
         rv   <= re;
      end
   end

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         rptr   <= '0;
         half   <= 1'b0;
         half_q <= 1'b0;
      end else if (dreq) begin
         rptr <= dadr;
         half <= 1'b0;
      end else if (re) begin
         rptr   <= rptr + {{(`BRG_BUF_AW-1){1'b0}}, (dqtype | half)};
         half   <= ~dqtype & ~half;   // toggles only in x16
         half_q <= half;
      end
   end

   // x16 folds one buffer half onto lanes 0 and 2
   always_comb begin
      if (dqtype) begin
         rdt_nx = wbuf.rdata;
         ben_nx = wbuf.rben_n;
      end else begin
         rdt_nx = '0;
         ben_nx = '1;
         rdt_nx.lanes[0]    = half_q ? wbuf.rdata.lanes[2] : wbuf.rdata.lanes[0];
         rdt_nx.lanes[2]    = half_q ? wbuf.rdata.lanes[3] : wbuf.rdata.lanes[1];
         ben_nx[0*LB +: LB] = half_q ? wbuf.rben_n[2*LB +: LB] : wbuf.rben_n[0*LB +: LB];
         ben_nx[2*LB +: LB] = half_q ? wbuf.rben_n[3*LB +: LB] : wbuf.rben_n[1*LB +: LB];
      end
   end

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         arb_rdt   <= '0;
         arb_ben_n <= '1;
      end else if (rv) begin
         arb_rdt   <= rdt_nx;
         arb_ben_n <= ben_nx;
      end
   end

   assign wbuf.re    = re;
   assign wbuf.ra    = rptr;
   assign drain_done = dend;

endmodule

// File: wdata_buffer.sv
// 16 x 128-bit staging store; a read returns the word as it was before a same-cycle write
`timescale 1ns/1ps
`include "bridge_config.svh"

module wdata_buffer (
   input  logic      CLK,
   input  logic      ZRESET,
   wbuf_if.buffer    wbuf
);

   localparam int DEPTH = 1 << `BRG_BUF_AW;

   mba_pkg::mba_word_u     mem      [DEPTH];
   logic [`BRG_STRB_W-1:0] strb_mem [DEPTH];
   logic [DEPTH-1:0]       written;   // entry touched since last clr

   mba_pkg::mba_word_u     word_q;
   logic [`BRG_STRB_W-1:0] strb_q;

   // first write after clr also zeroes the lanes it does not enable
   always_ff @(posedge CLK) begin
      if (wbuf.we) begin
         for (int i = 0; i < `BRG_STRB_W; i++) begin
            if (wbuf.wbe[i]) begin
               mem[wbuf.wa].bytes[i] <= wbuf.wdata.bytes[i];
               strb_mem[wbuf.wa][i]  <= 1'b1;
            end else if (!written[wbuf.wa]) begin
               mem[wbuf.wa].bytes[i] <= 8'h00;
               strb_mem[wbuf.wa][i]  <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         written <= '0;
      end else if (wbuf.clr) begin
         written <= '0;
      end else if (wbuf.we) begin
         written[wbuf.wa] <= 1'b1;
      end
   end

   // ====================
   // read port
   // ====================
   always_ff @(posedge CLK) begin
      if (wbuf.re) begin
         word_q <= mem[wbuf.ra];
         strb_q <= strb_mem[wbuf.ra];
      end
   end

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) wbuf.rhit <= 1'b0;
      else if (wbuf.re) wbuf.rhit <= written[wbuf.ra];
   end

   assign wbuf.rdata  = wbuf.rhit ? word_q : '0;       // stale entry reads empty
   assign wbuf.rben_n = wbuf.rhit ? ~strb_q : '1;

endmodule

// File: wbeat_steer.sv
// beats land one cycle after acceptance; INCR bursts must not leave the 256-byte window
`timescale 1ns/1ps
`include "bridge_config.svh"

module wbeat_steer (
   input  logic                   CLK,
   input  logic                   ZRESET,
   input  logic [`BRG_DATA_W-1:0] wdata,
   input  logic [`BRG_STRB_W-1:0] wstrb,
   input  logic                   wlast,
   input  logic                   wvalid,
   input  logic                   drain_done,
   output logic                   wready,
   output logic                   burst_done,
   burst_cmd_if.steer             cmd,
   wbuf_if.writer                 wbuf
);

   localparam int AW = `BRG_ADDR_W;

   // ====================
   // burst state
   // ====================
   logic          take_q;
   logic          active;    // command popped, not yet drained
   logic          last_st;   // wlast taken, waiting for drain
   logic [7:0]    len_q;
   logic [2:0]    size_q;
   logic [1:0]    burst_q;
   logic [AW-1:0] addr_q;

   logic                   accept;
   logic [4:0]             pop_bytes;
   logic [AW-1:0]          align_mask;
   logic [4:0]             bytes_n;
   logic [AW-1:0]          step;
   logic [12:0]            wrap_span;
   logic [AW-1:0]          wrap_low;
   logic [AW-1:0]          addr_incr;
   logic [AW-1:0]          addr_next;
   logic [31:0]            lane_ones;
   logic [31:0]            lane_shift;

   // beat register
   logic                   beat_vld;
   logic                   beat_last;
   logic [`BRG_DATA_W-1:0] wdata_q;
   logic [`BRG_STRB_W-1:0] wstrb_q;

   assign accept     = wvalid & wready;
   assign pop_bytes  = axi_pkg::beat_bytes(cmd.size);
   assign align_mask = ~({{(AW-5){1'b0}}, pop_bytes} - 1'b1);

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         take_q  <= 1'b0;
         active  <= 1'b0;
         last_st <= 1'b0;
         wready  <= 1'b0;
      end else begin
         take_q  <= cmd.valid & ~active & ~take_q;   // pop one cycle after head shows
         if (take_q)          active <= 1'b1;
         else if (drain_done) active <= 1'b0;
         if (accept & wlast)  last_st <= 1'b1;
         else if (drain_done) last_st <= 1'b0;
         wready  <= active & ~last_st & ~(accept & wlast);
      end
   end

   // ====================
   // address stepping
   // ====================
   assign bytes_n   = axi_pkg::beat_bytes(size_q);
   assign step      = {{(AW-5){1'b0}}, bytes_n};
   assign wrap_span = ({5'd0, len_q} + 13'd1) * {8'd0, bytes_n};
   assign wrap_low  = (wrap_span >= 13'd256) ? {AW{1'b1}} : wrap_span[AW-1:0] - 1'b1;
   assign addr_incr = addr_q + step;
   assign addr_next = (burst_q == axi_pkg::BURST_WRAP) ?
                      ((addr_q & ~wrap_low) | (addr_incr & wrap_low)) : addr_incr;

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         len_q   <= '0;
         size_q  <= '0;
         burst_q <= '0;
         addr_q  <= '0;
      end else if (take_q) begin
         len_q   <= cmd.len;
         size_q  <= cmd.size;
         burst_q <= cmd.burst;
         addr_q  <= cmd.addr & align_mask;   // down to beat size
      end else if (beat_vld) begin
         addr_q  <= addr_next;
      end
   end

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         beat_vld  <= 1'b0;
         beat_last <= 1'b0;
      end else begin
         beat_vld  <= accept;
         beat_last <= accept & wlast;
      end
   end

   always_ff @(posedge CLK) begin
      if (accept) begin
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   // lanes picked by size and offset
   assign lane_ones  = (32'd1 << bytes_n) - 32'd1;
   assign lane_shift = lane_ones << addr_q[3:0];

   assign cmd.take   = take_q;
   assign wbuf.clr   = take_q;
   assign wbuf.we    = beat_vld;
   assign wbuf.wa    = addr_q[AW-1 -: `BRG_BUF_AW];
   assign wbuf.wbe   = lane_shift[`BRG_STRB_W-1:0] & wstrb_q;
   assign wbuf.wdata = wdata_q;
   assign burst_done = beat_vld & beat_last;

endmodule

// File: aw_cmd_queue.sv
// 4-deep command FIFO with no back-pressure; a push into a full queue is lost
`timescale 1ns/1ps
`include "bridge_config.svh"

module aw_cmd_queue (
   input  logic                   CLK,
   input  logic                   ZRESET,
   input  logic                   push,
   input  logic [`BRG_ADDR_W-1:0] push_addr,
   input  logic [7:0]             push_len,
   input  logic [2:0]             push_size,
   input  logic [1:0]             push_burst,
   burst_cmd_if.queue             cmd
);

   localparam int DEPTH = 1 << `BRG_CMDQ_AW;

   logic [`BRG_ADDR_W-1:0] addr_mem  [DEPTH];
   logic [7:0]             len_mem   [DEPTH];
   logic [2:0]             size_mem  [DEPTH];
   logic [1:0]             burst_mem [DEPTH];

   logic [`BRG_CMDQ_AW-1:0] wptr;
   logic [`BRG_CMDQ_AW-1:0] rptr;
   logic [`BRG_CMDQ_AW:0]   count;   // top bit set only when full
   logic                    do_push;
   logic                    do_pop;

   assign do_push = push & ~count[`BRG_CMDQ_AW];
   assign do_pop  = cmd.take & cmd.valid;

   always_ff @(posedge CLK) begin
      if (do_push) begin
         addr_mem[wptr]  <= push_addr;
         len_mem[wptr]   <= push_len;
         size_mem[wptr]  <= push_size;
         burst_mem[wptr] <= push_burst;
      end
   end

   always_ff @(posedge CLK or negedge ZRESET) begin
      if (!ZRESET) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (do_push) wptr <= wptr + 1'b1;   // wraps at depth
         if (do_pop)  rptr <= rptr + 1'b1;
         count <= count + {{`BRG_CMDQ_AW{1'b0}}, do_push} - {{`BRG_CMDQ_AW{1'b0}}, do_pop};
      end
   end

   // head of queue
   assign cmd.valid = (count != '0);
   assign cmd.addr  = addr_mem[rptr];
   assign cmd.len   = len_mem[rptr];
   assign cmd.size  = size_mem[rptr];
   assign cmd.burst = burst_mem[rptr];

endmodule

// File: bridge_ifs.sv
// internal links of the bridge; take and clr are single-cycle strobes
`timescale 1ns/1ps
`include "bridge_config.svh"

// head of the write-address queue
interface burst_cmd_if;
   logic                   valid;   // head present
   logic                   take;    // pop strobe, only while valid
   logic [`BRG_ADDR_W-1:0] addr;
   logic [7:0]             len;
   logic [2:0]             size;
   logic [1:0]             burst;

   modport queue (output valid, addr, len, size, burst, input take);
   modport steer (input valid, addr, len, size, burst, output take);
endinterface

// staging buffer port, write and read may share a cycle
interface wbuf_if;
   // write side
   logic                   we;
   logic [`BRG_BUF_AW-1:0] wa;
   logic [`BRG_STRB_W-1:0] wbe;
   mba_pkg::mba_word_u     wdata;
   logic                   clr;     // drops all written flags
   // read side
   logic                   re;
   logic [`BRG_BUF_AW-1:0] ra;
   mba_pkg::mba_word_u     rdata;
   logic [`BRG_STRB_W-1:0] rben_n;
   logic                   rhit;

   modport writer (output we, wa, wbe, wdata, clr);
   modport reader (output re, ra, input rdata, rben_n, rhit);
   modport buffer (input we, wa, wbe, wdata, clr, re, ra, output rdata, rben_n, rhit);
endinterface

// File: mba_pkg.sv
// arbiter side word layout; lane byte enables are active low on the bus
package mba_pkg;

   localparam int LANE_W = 32;   // one arbiter lane
   localparam int LANES  = 4;    // lanes per buffer word

   // ====================
   // buffer word
   // ====================
   // written byte by byte from the AXI side,
   // read lane by lane on the drain side
   typedef union packed {
      logic [LANES*LANE_W/8-1:0][7:0] bytes;
      logic [LANES-1:0][LANE_W-1:0]   lanes;
   } mba_word_u;

endpackage

// File: axi_pkg.sv
// AXI write-address codes; FIXED bursts are not decoded and step like INCR
package axi_pkg;

   // burst type codes
   localparam logic [1:0] BURST_INCR = 2'd1;
   localparam logic [1:0] BURST_WRAP = 2'd2;

   // size codes, bytes per beat
   localparam logic [2:0] SIZE_1  = 3'd0;
   localparam logic [2:0] SIZE_2  = 3'd1;
   localparam logic [2:0] SIZE_4  = 3'd2;
   localparam logic [2:0] SIZE_8  = 3'd3;

   // byte count of one beat, codes above 16 bytes saturate
   function automatic logic [4:0] beat_bytes(input logic [2:0] size);
      case (size)
         SIZE_1:  beat_bytes = 5'd1;
         SIZE_2:  beat_bytes = 5'd2;
         SIZE_4:  beat_bytes = 5'd4;
         SIZE_8:  beat_bytes = 5'd8;
         default: beat_bytes = 5'd16;
      endcase
   endfunction

endpackage

// File: bridge_config.svh
// widths and depths of the bridge; one burst must stay inside one 256-byte window
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// ====================
// data path
// ====================
`define BRG_DATA_W   128   // beat and buffer word width
`define BRG_STRB_W   16    // byte lanes per beat

// ====================
// addressing
// ====================
`define BRG_ADDR_W   8     // byte address inside the window
`define BRG_BUF_AW   4     // staging buffer index, 16 entries

// command queue index, 4 entries
`define BRG_CMDQ_AW  2

`endif
